/* hdl/rv_pkg.sv */
package rv_pkg;

    localparam int xlen = 64;
    localparam logic [xlen-1:0] pc_reset = '0;

    // major opcodes
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, six readings
    typedef union packed {
        r_fmt_t fmt_r;
        i_fmt_t fmt_i;
        s_fmt_t fmt_s;
        b_fmt_t fmt_b;
        u_fmt_t fmt_u;
        j_fmt_t fmt_j;
    } inst_t;

    typedef struct packed {
        logic alu_lui;
        logic alu_sra;
        logic alu_srl;
        logic alu_sll;
        logic alu_xor;
        logic alu_or;
        logic alu_and;
        logic alu_sltu;
        logic alu_slt;
        logic alu_sub;
        logic alu_add;
    } alu_op_t;

    typedef struct packed {
        logic pc;
        logic rdata1;
    } src1_sel_t;

    typedef struct packed {
        logic imm_s;
        logic four;
        logic imm_u;
        logic imm_i;
        logic rdata2;
    } src2_sel_t;

    typedef struct packed {
        logic bge;  // bge and bgeu
        logic blt;  // blt and bltu
        logic bne;
        logic beq;
        logic jalr;
        logic jal;
        logic seq;
    } npc_sel_t;

    typedef struct packed {
        alu_op_t    alu_op;
        logic       rf_we;
        src1_sel_t  src1_sel;
        src2_sel_t  src2_sel;
        npc_sel_t   npc_sel;
        logic       unsigned_cmp;
        logic       wb_from_mem;
        logic       mem_ena;
        logic [7:0] mem_wen;
    } ctrl_t;

    typedef enum logic [2:0] {
        s_fetch = 3'd0,
        s_exec  = 3'd1,
        s_mem   = 3'd2,
        s_wb    = 3'd3,
        s_halt  = 3'd4
    } state_t;

endpackage

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  rv_pkg::alu_op_t         op,
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    output logic [rv_pkg::xlen-1:0] y
);

    logic [5:0]              shamt;
    logic [rv_pkg::xlen-1:0] add_res, sub_res, slt_res, sltu_res;
    logic [rv_pkg::xlen-1:0] and_res, or_res, xor_res;
    logic [rv_pkg::xlen-1:0] sll_res, srl_res, sra_res;

    assign shamt = b[5:0];

    assign add_res  = a + b;
    assign sub_res  = a - b;
    assign slt_res  = {{(rv_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
    assign sltu_res = {{(rv_pkg::xlen-1){1'b0}}, a < b};
    assign and_res  = a & b;
    assign or_res   = a | b;
    assign xor_res  = a ^ b;
    assign sll_res  = a << shamt;
    assign srl_res  = a >> shamt;
    assign sra_res  = $signed(a) >>> shamt;

    // and-or mux over the one-hot op
    assign y = ({rv_pkg::xlen{op.alu_add}}  & add_res)
             | ({rv_pkg::xlen{op.alu_sub}}  & sub_res)
             | ({rv_pkg::xlen{op.alu_slt}}  & slt_res)
             | ({rv_pkg::xlen{op.alu_sltu}} & sltu_res)
             | ({rv_pkg::xlen{op.alu_and}}  & and_res)
             | ({rv_pkg::xlen{op.alu_or}}   & or_res)
             | ({rv_pkg::xlen{op.alu_xor}}  & xor_res)
             | ({rv_pkg::xlen{op.alu_sll}}  & sll_res)
             | ({rv_pkg::xlen{op.alu_srl}}  & srl_res)
             | ({rv_pkg::xlen{op.alu_sra}}  & sra_res)
             | ({rv_pkg::xlen{op.alu_lui}}  & b);  // lui passes immU

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    we,
    input  logic [4:0]              waddr,
    input  logic [4:0]              raddr1,
    input  logic [4:0]              raddr2,
    input  logic [rv_pkg::xlen-1:0] wdata,
    output logic [rv_pkg::xlen-1:0] rdata1,
    output logic [rv_pkg::xlen-1:0] rdata2
);

    logic [rv_pkg::xlen-1:0] regs [1:31];  // no storage for x0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

/* hdl/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pc_load,
    input  rv_pkg::npc_sel_t        npc_sel,
    input  logic                    unsigned_cmp,
    input  logic [rv_pkg::xlen-1:0] rs1_val,
    input  logic [rv_pkg::xlen-1:0] rs2_val,
    input  logic [rv_pkg::xlen-1:0] branch_imm,
    input  logic [rv_pkg::xlen-1:0] jal_imm,
    input  logic [rv_pkg::xlen-1:0] i_imm,
    output logic [rv_pkg::xlen-1:0] pc
);

    logic                    eq, lt, taken;
    logic [rv_pkg::xlen-1:0] seq_pc, jalr_sum, npc;

    assign eq = (rs1_val == rs2_val);
    assign lt = unsigned_cmp ? (rs1_val < rs2_val)
                             : ($signed(rs1_val) < $signed(rs2_val));

    assign taken = (npc_sel.beq & eq) | (npc_sel.bne & ~eq)
                 | (npc_sel.blt & lt) | (npc_sel.bge & ~lt);

    assign seq_pc   = pc + 64'd4;
    assign jalr_sum = rs1_val + i_imm;

    always_comb begin
        if (npc_sel.jal)
            npc = pc + jal_imm;
        else if (npc_sel.jalr)
            npc = {jalr_sum[rv_pkg::xlen-1:1], 1'b0};  // low bit cleared
        else if (taken)
            npc = pc + branch_imm;
        else
            npc = seq_pc;  // seq or branch not taken
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= rv_pkg::pc_reset;
        end else if (pc_load) begin
            pc <= npc;
        end
    end

endmodule

/* hdl/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  rv_pkg::inst_t inst,
    output rv_pkg::ctrl_t ctrl,
    output logic          illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    logic inst_addi, inst_lui, inst_auipc, inst_jal, inst_jalr;
    logic inst_add, inst_sub, inst_slt, inst_sltu, inst_and;
    logic inst_or, inst_xor, inst_sll, inst_srl, inst_sra;
    logic inst_beq, inst_bne, inst_blt, inst_bltu, inst_bge, inst_bgeu;
    logic inst_ld, inst_sd;
    logic r_type, b_type, mem, legal;
    logic reg_f7_zero, reg_f7_alt;

    assign opcode = inst.fmt_r.opcode;
    assign funct3 = inst.fmt_r.funct3;
    assign funct7 = inst.fmt_r.funct7;

    assign reg_f7_zero = (opcode == rv_pkg::op_reg) && (funct7 == 7'b0000000);
    assign reg_f7_alt  = (opcode == rv_pkg::op_reg) && (funct7 == 7'b0100000);

    assign inst_addi  = (opcode == rv_pkg::op_imm) && (funct3 == 3'b000);
    assign inst_lui   = (opcode == rv_pkg::op_lui);
    assign inst_auipc = (opcode == rv_pkg::op_auipc);
    assign inst_jal   = (opcode == rv_pkg::op_jal);
    assign inst_jalr  = (opcode == rv_pkg::op_jalr) && (funct3 == 3'b000);

    assign inst_add  = reg_f7_zero && (funct3 == 3'b000);
    assign inst_sub  = reg_f7_alt  && (funct3 == 3'b000);
    assign inst_sll  = reg_f7_zero && (funct3 == 3'b001);
    assign inst_slt  = reg_f7_zero && (funct3 == 3'b010);
    assign inst_sltu = reg_f7_zero && (funct3 == 3'b011);
    assign inst_xor  = reg_f7_zero && (funct3 == 3'b100);
    assign inst_srl  = reg_f7_zero && (funct3 == 3'b101);
    assign inst_sra  = reg_f7_alt  && (funct3 == 3'b101);
    assign inst_or   = reg_f7_zero && (funct3 == 3'b110);
    assign inst_and  = reg_f7_zero && (funct3 == 3'b111);

    assign inst_beq  = (opcode == rv_pkg::op_branch) && (funct3 == 3'b000);
    assign inst_bne  = (opcode == rv_pkg::op_branch) && (funct3 == 3'b001);
    assign inst_blt  = (opcode == rv_pkg::op_branch) && (funct3 == 3'b100);
    assign inst_bge  = (opcode == rv_pkg::op_branch) && (funct3 == 3'b101);
    assign inst_bltu = (opcode == rv_pkg::op_branch) && (funct3 == 3'b110);
    assign inst_bgeu = (opcode == rv_pkg::op_branch) && (funct3 == 3'b111);

    assign inst_ld = (opcode == rv_pkg::op_load)  && (funct3 == 3'b011);
    assign inst_sd = (opcode == rv_pkg::op_store) && (funct3 == 3'b011);

    assign r_type = inst_add | inst_sub | inst_slt | inst_sltu | inst_and
                  | inst_or | inst_xor | inst_sll | inst_srl | inst_sra;
    assign b_type = inst_beq | inst_bne | inst_blt | inst_bltu | inst_bge | inst_bgeu;
    assign mem    = inst_ld | inst_sd;

    assign legal   = inst_addi | inst_lui | inst_auipc | inst_jal | inst_jalr
                   | r_type | b_type | mem;
    assign illegal = ~legal;

    // branches keep a compare op so alu_op stays one-hot
    assign ctrl.alu_op = '{
        alu_lui:  inst_lui,
        alu_sra:  inst_sra,
        alu_srl:  inst_srl,
        alu_sll:  inst_sll,
        alu_xor:  inst_xor,
        alu_or:   inst_or,
        alu_and:  inst_and,
        alu_sltu: inst_sltu | inst_bltu | inst_bgeu,
        alu_slt:  inst_slt | inst_blt | inst_bge,
        alu_sub:  inst_sub | inst_beq | inst_bne,
        alu_add:  inst_add | inst_addi | inst_auipc | inst_jal | inst_jalr | mem
    };

    assign ctrl.rf_we = inst_addi | inst_lui | inst_auipc | inst_jal | inst_jalr
                      | r_type | inst_ld;

    assign ctrl.src1_sel.pc     = inst_auipc | inst_jal | inst_jalr;
    assign ctrl.src1_sel.rdata1 = inst_addi | inst_lui | r_type | b_type | mem; // lui ignores a

    assign ctrl.src2_sel.imm_s  = inst_sd;
    assign ctrl.src2_sel.four   = inst_jal | inst_jalr;  // link value
    assign ctrl.src2_sel.imm_u  = inst_lui | inst_auipc;
    assign ctrl.src2_sel.imm_i  = inst_addi | inst_ld;
    assign ctrl.src2_sel.rdata2 = r_type | b_type;

    assign ctrl.npc_sel.bge  = inst_bge | inst_bgeu;
    assign ctrl.npc_sel.blt  = inst_blt | inst_bltu;
    assign ctrl.npc_sel.bne  = inst_bne;
    assign ctrl.npc_sel.beq  = inst_beq;
    assign ctrl.npc_sel.jalr = inst_jalr;
    assign ctrl.npc_sel.jal  = inst_jal;
    assign ctrl.npc_sel.seq  = inst_addi | inst_lui | inst_auipc | r_type | mem;

    assign ctrl.unsigned_cmp = inst_bltu | inst_bgeu;
    assign ctrl.wb_from_mem  = inst_ld;
    assign ctrl.mem_ena      = mem;
    assign ctrl.mem_wen      = {8{inst_sd}};

    always_comb begin
        assert final (illegal || ($onehot(ctrl.npc_sel) && $onehot(ctrl.src1_sel)
                                  && $onehot(ctrl.alu_op)))
            else $error("control_unit: select field not one-hot for %h", inst);
    end

endmodule

/* hdl/core_fsm.sv */
`timescale 1ns/1ps

module core_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic mem_ena,
    input  logic illegal,
    output logic ir_load,
    output logic pc_load,
    output logic rf_wr_en,
    output logic mem_phase,
    output logic retire,
    output logic halted
);

    rv_pkg::state_t state, state_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= rv_pkg::s_fetch;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            rv_pkg::s_fetch: state_nxt = rv_pkg::s_exec;
            rv_pkg::s_exec: begin
                if (illegal)
                    state_nxt = rv_pkg::s_halt;
                else if (mem_ena)
                    state_nxt = rv_pkg::s_mem;  // ld / sd only
                else
                    state_nxt = rv_pkg::s_wb;
            end
            rv_pkg::s_mem:  state_nxt = rv_pkg::s_wb;
            rv_pkg::s_wb:   state_nxt = rv_pkg::s_fetch;
            default:        state_nxt = rv_pkg::s_halt;
        endcase
    end

    assign ir_load   = (state == rv_pkg::s_fetch);
    assign mem_phase = (state == rv_pkg::s_mem);
    assign rf_wr_en  = (state == rv_pkg::s_wb);
    assign pc_load   = (state == rv_pkg::s_wb);
    assign retire    = (state == rv_pkg::s_wb);
    assign halted    = (state == rv_pkg::s_halt);

    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {rv_pkg::s_fetch, rv_pkg::s_exec, rv_pkg::s_mem,
                      rv_pkg::s_wb, rv_pkg::s_halt});

    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        (state == rv_pkg::s_halt) |=> (state == rv_pkg::s_halt));

endmodule

/* hdl/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [rv_pkg::xlen-1:0] imem_addr,
    input  logic [31:0]             imem_rdata,
    output logic [rv_pkg::xlen-1:0] dmem_addr,
    output logic [rv_pkg::xlen-1:0] dmem_wdata,
    input  logic [rv_pkg::xlen-1:0] dmem_rdata,
    output logic                    dmem_ena,
    output logic [7:0]              dmem_wen,
    output logic                    retire,
    output logic [rv_pkg::xlen-1:0] retire_pc,
    output logic                    halted
);

    rv_pkg::inst_t           ir;
    rv_pkg::ctrl_t           ctrl;
    logic                    illegal, ir_load, pc_load, rf_wr_en, mem_phase;
    logic [rv_pkg::xlen-1:0] pc, rdata1, rdata2, alu_a, alu_b, alu_y;
    logic [rv_pkg::xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [rv_pkg::xlen-1:0] load_data, wb_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir <= 32'h0000_0013;  // addi x0, x0, 0
        end else if (ir_load) begin
            ir <= imem_rdata;
        end
    end

    // ld data sampled while dmem is enabled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_data <= '0;
        end else if (mem_phase) begin
            load_data <= dmem_rdata;
        end
    end

    assign imm_i = {{52{ir.fmt_i.imm_11_0[11]}}, ir.fmt_i.imm_11_0};
    assign imm_s = {{52{ir.fmt_s.imm_11_5[6]}}, ir.fmt_s.imm_11_5, ir.fmt_s.imm_4_0};
    assign imm_b = {{52{ir.fmt_b.imm_12}}, ir.fmt_b.imm_11, ir.fmt_b.imm_10_5,
                    ir.fmt_b.imm_4_1, 1'b0};
    assign imm_u = {{32{ir.fmt_u.imm_31_12[19]}}, ir.fmt_u.imm_31_12, 12'b0};
    assign imm_j = {{44{ir.fmt_j.imm_20}}, ir.fmt_j.imm_19_12, ir.fmt_j.imm_11,
                    ir.fmt_j.imm_10_1, 1'b0};

    control_unit u_control_unit (.inst(ir), .ctrl(ctrl), .illegal(illegal));

    core_fsm u_core_fsm (
        .clk(clk), .rst_n(rst_n), .mem_ena(ctrl.mem_ena), .illegal(illegal),
        .ir_load(ir_load), .pc_load(pc_load), .rf_wr_en(rf_wr_en),
        .mem_phase(mem_phase), .retire(retire), .halted(halted)
    );

    pc_unit u_pc_unit (
        .clk(clk), .rst_n(rst_n), .pc_load(pc_load), .npc_sel(ctrl.npc_sel),
        .unsigned_cmp(ctrl.unsigned_cmp), .rs1_val(rdata1), .rs2_val(rdata2),
        .branch_imm(imm_b), .jal_imm(imm_j), .i_imm(imm_i), .pc(pc)
    );

    assign alu_a = ({rv_pkg::xlen{ctrl.src1_sel.rdata1}} & rdata1)
                 | ({rv_pkg::xlen{ctrl.src1_sel.pc}}     & pc);
    assign alu_b = ({rv_pkg::xlen{ctrl.src2_sel.rdata2}} & rdata2)
                 | ({rv_pkg::xlen{ctrl.src2_sel.imm_i}}  & imm_i)
                 | ({rv_pkg::xlen{ctrl.src2_sel.imm_u}}  & imm_u)
                 | ({rv_pkg::xlen{ctrl.src2_sel.four}}   & 64'd4)
                 | ({rv_pkg::xlen{ctrl.src2_sel.imm_s}}  & imm_s);

    alu u_alu (.op(ctrl.alu_op), .a(alu_a), .b(alu_b), .y(alu_y));

    assign wb_data = ctrl.wb_from_mem ? load_data : alu_y;

    reg_file u_reg_file (
        .clk(clk), .rst_n(rst_n), .we(rf_wr_en & ctrl.rf_we), .waddr(ir.fmt_r.rd),
        .raddr1(ir.fmt_r.rs1), .raddr2(ir.fmt_r.rs2), .wdata(wb_data),
        .rdata1(rdata1), .rdata2(rdata2)
    );

    assign imem_addr  = pc;
    assign dmem_addr  = alu_y;
    assign dmem_wdata = rdata2;
    assign dmem_ena   = mem_phase & ctrl.mem_ena;
    assign dmem_wen   = {8{mem_phase}} & ctrl.mem_wen;
    assign retire_pc  = pc;  // pc moves at the end of s_wb

endmodule

/* sim/core_checker.sv */
`timescale 1ns/1ps

module core_checker (
    input logic        clk,
    input logic        rst_n,
    input logic        done,
    input logic [63:0] dmem_addr,
    input logic [63:0] dmem_wdata,
    input logic        dmem_ena,
    input logic [7:0]  dmem_wen,
    input logic        retire,
    input logic [63:0] retire_pc,
    input logic        halted
);

    string       st_name [64];
    logic [63:0] st_addr [64];
    logic [63:0] st_data [64];
    logic [63:0] exp_pc [256];
    int          n_st = 0;
    int          n_pc = 0;
    int          got_st = 0;
    int          got_pc = 0;
    int          errors = 0;
    logic        reported = 1'b0;

    task automatic expect_store(input string name, input logic [63:0] a, input logic [63:0] d);
        st_name[n_st] = name;
        st_addr[n_st] = a;
        st_data[n_st] = d;
        n_st++;
    endtask

    task automatic expect_retire(input logic [63:0] p);
        exp_pc[n_pc] = p;
        n_pc++;
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (dmem_wen != 8'h00 && (dmem_wen != 8'hFF || !dmem_ena)) begin
                $display("dmem_wen is %h outside a store cycle", dmem_wen);
                errors++;
            end
            if (halted && (retire || dmem_ena)) begin
                $display("core retired or touched memory after halting");
                errors++;
            end
            if (dmem_ena && dmem_wen == 8'hFF) begin
                if (got_st >= n_st) begin
                    $display("unexpected store to %h", dmem_addr);
                    errors++;
                end else if (dmem_addr != st_addr[got_st]) begin
                    $display("Mismatch %s addr: expected %h, actual %h",
                             st_name[got_st], st_addr[got_st], dmem_addr);
                    errors++;
                end else if (dmem_wdata != st_data[got_st]) begin
                    $display("Mismatch %s: expected %h, actual %h",
                             st_name[got_st], st_data[got_st], dmem_wdata);
                    errors++;
                end
                got_st++;
            end
            if (retire) begin
                if (got_pc >= n_pc) begin
                    $display("unexpected retire at pc %h", retire_pc);
                    errors++;
                end else if (retire_pc != exp_pc[got_pc]) begin
                    $display("Mismatch retire_pc #%0d: expected %h, actual %h",
                             got_pc, exp_pc[got_pc], retire_pc);
                    errors++;
                end
                got_pc++;
            end
            if (done && !reported) begin
                reported <= 1'b1;
                if (got_st != n_st || got_pc != n_pc) begin
                    $display("store or retire count differs from the program");
                    errors++;
                end
            end
        end
    end

endmodule

/* sim/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

    logic        clk, rst_n, done;
    logic [63:0] imem_addr, dmem_addr, dmem_wdata, dmem_rdata, retire_pc;
    logic [31:0] imem_rdata;
    logic        dmem_ena, retire, halted;
    logic [7:0]  dmem_wen;

    logic [31:0] prog [0:127];
    logic [63:0] dmem [0:63];
    logic [63:0] preload [0:63];
    int          n_inst, st_off, seed, cycles, timeouts;

    // alu cases use rs1 = x2 = -7 and rs2 = x3 = 5
    string       alu_name [10] = '{"add", "sub", "sll", "slt", "sltu",
                                   "xor", "srl", "sra", "or", "and"};
    logic [6:0]  alu_f7 [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00,
                                 7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
    logic [2:0]  alu_f3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    logic [63:0] alu_exp [10] = '{64'hFFFF_FFFF_FFFF_FFFE, 64'hFFFF_FFFF_FFFF_FFF4,
                                  64'hFFFF_FFFF_FFFF_FF20,
                                  64'd1, 64'd0, 64'hFFFF_FFFF_FFFF_FFFC,
                                  64'h07FF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF,
                                  64'hFFFF_FFFF_FFFF_FFFD, 64'd1};
    // per branch the funct3, a taken rs1/rs2 pair and a not-taken pair
    // with x2 = -7 and x3 = x6 = 5
    logic [2:0]  br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd6, 3'd5, 3'd7};
    int          br_t1 [6] = '{3, 2, 2, 3, 3, 2};
    int          br_t2 [6] = '{6, 3, 3, 2, 2, 3};
    int          br_n1 [6] = '{2, 3, 3, 2, 2, 3};
    int          br_n2 [6] = '{3, 6, 2, 3, 3, 2};
    int          ld_slot [3] = '{0, 3, 5};

    rv_core UUT (
        .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata),
        .dmem_ena(dmem_ena), .dmem_wen(dmem_wen), .retire(retire),
        .retire_pc(retire_pc), .halted(halted)
    );

    core_checker chk (
        .clk(clk), .rst_n(rst_n), .done(done), .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata), .dmem_ena(dmem_ena), .dmem_wen(dmem_wen),
        .retire(retire), .retire_pc(retire_pc), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    assign imem_rdata = (imem_addr < 64'd512) ? prog[imem_addr[8:2]] : 32'hFFFF_FFFF;
    assign dmem_rdata = dmem[dmem_addr[8:3]];

    always @(posedge clk) begin
        if (dmem_wen == 8'hFF)
            dmem[dmem_addr[8:3]] <= dmem_wdata;
    end

    function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    task automatic emit(input logic [31:0] word, input bit runs);
        prog[n_inst] = word;
        if (runs)
            chk.expect_retire(64'(4 * n_inst));
        n_inst++;
    endtask

    // sd rs, st_off(x1) and the value it must carry
    task automatic store_check(input string name, input int rs, input logic [63:0] value);
        emit({st_off[11:5], rs[4:0], 5'd1, 3'b011, st_off[4:0], 7'b0100011}, 1'b1);
        chk.expect_store(name, 64'(256 + st_off), value);
        st_off += 8;
    endtask

    initial begin
        logic [63:0] p;
        rst_n = 1'b0;
        done = 1'b0;
        n_inst = 0;
        st_off = 0;
        timeouts = 0;
        seed = 3381;
        for (int i = 0; i < 64; i++) begin
            preload[i] = {$random(seed), $random(seed)};
            dmem[i] <= preload[i];
        end
        for (int i = 0; i < 128; i++)
            prog[i] = 32'd0;

        emit(enc_i(256, 0, 0, 1, 7'h13), 1'b1);
        emit(enc_i(-7, 0, 0, 2, 7'h13), 1'b1);
        emit(enc_i(5, 0, 0, 3, 7'h13), 1'b1);
        emit(enc_i(5, 0, 0, 6, 7'h13), 1'b1);
        for (int i = 0; i < 10; i++) begin
            emit(enc_r(int'(alu_f7[i]), 3, 2, int'(alu_f3[i]), 4), 1'b1);
            store_check(alu_name[i], 4, alu_exp[i]);
        end
        emit({20'h12345, 5'd4, 7'b0110111}, 1'b1);
        store_check("lui", 4, 64'h0000_0000_1234_5000);
        emit({20'h80000, 5'd4, 7'b0110111}, 1'b1);
        store_check("lui_neg", 4, 64'hFFFF_FFFF_8000_0000);
        p = 64'(4 * n_inst);
        emit({20'h00001, 5'd4, 7'b0010111}, 1'b1);
        store_check("auipc", 4, p + 64'h1000);
        p = 64'(4 * n_inst);
        emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd4, 7'b1101111}, 1'b1);  // jal x4, +8
        emit(enc_i(1, 7, 0, 7, 7'h13), 1'b0);
        store_check("jal", 4, p + 64'd4);
        p = 64'(4 * n_inst);
        emit({20'h00000, 5'd5, 7'b0010111}, 1'b1);
        emit(enc_i(13, 5, 0, 4, 7'h67), 1'b1);  // odd target has its low bit dropped
        emit(enc_i(1, 7, 0, 7, 7'h13), 1'b0);
        store_check("jalr", 4, p + 64'd8);
        for (int i = 0; i < 6; i++) begin
            emit(enc_b(8, br_t2[i], br_t1[i], int'(br_f3[i])), 1'b1);
            emit(enc_i(1, 7, 0, 7, 7'h13), 1'b0);
            emit(enc_b(8, br_n2[i], br_n1[i], int'(br_f3[i])), 1'b1);
            emit(enc_i(1, 7, 0, 7, 7'h13), 1'b1);
        end
        store_check("branch_fall_through", 7, 64'd6);
        for (int i = 0; i < 3; i++) begin
            emit(enc_i(8 * ld_slot[i], 0, 3, 8, 7'h03), 1'b1);
            store_check("ld_sd", 8, preload[ld_slot[i]]);
        end
        emit(enc_i(123, 0, 0, 0, 7'h13), 1'b1);
        emit(enc_r(0, 3, 2, 0, 0), 1'b1);
        store_check("x0_zero", 0, 64'd0);
        emit(32'hFFFF_FFFF, 1'b0);

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        cycles = 0;
        while (!halted && cycles < 4000) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("timeout: core did not halt within %0d cycles", cycles);
            timeouts++;
        end else begin
            repeat (10) @(posedge clk);  // nothing may retire now
            done <= 1'b1;
            repeat (3) @(negedge clk);
        end
        $display("errors: %0d, timeouts: %0d, stores: %0d of %0d, retires: %0d of %0d",
                 chk.errors, timeouts, chk.got_st, chk.n_st, chk.got_pc, chk.n_pc);
        if (chk.errors == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
hdl/rv_pkg.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/pc_unit.sv
hdl/control_unit.sv
hdl/core_fsm.sv
hdl/rv_core.sv
sim/core_checker.sv
sim/tb_rv_core.sv

/* run_sim.sh */
#!/bin/bash
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_rv_core -f sources.f -o sim_rv_core \
    > build.log 2>&1 \
    && ./obj_dir/sim_rv_core > sim.log 2>&1 \
    || { echo "build or run failed, see build.log and sim.log"; exit 1; }

grep -q "TEST FAILED" sim.log \
    && { echo "simulation failed, see sim.log"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
